//--- src/mem_bus_pkg.sv
package mem_bus_pkg;

    typedef logic [63:0] addr_t;
    typedef logic [63:0] data_t;

    // access width, matches the low two bits of the core's ls code
    typedef enum logic [1:0] {
        SIZE_BYTE   = 2'd0,
        SIZE_HALF   = 2'd1,
        SIZE_WORD   = 2'd2,
        SIZE_DOUBLE = 2'd3
    } size_e;

    // lb lh lw ld lbu lhu lwu, stores use the same codes with bit 2 clear
    typedef union packed {
        logic [2:0] raw;
        struct packed {
            logic  zero_ext;
            size_e size;
        } fields;
    } ls_type_u;

    typedef enum logic [1:0] {
        REGION_NONE  = 2'd0,
        REGION_RAM   = 2'd1,
        REGION_SDRAM = 2'd2,
        REGION_KEY   = 2'd3
    } region_e;

    // address map
    localparam addr_t RAM_BASE    = 64'h0000_0000_0000_1000;
    localparam addr_t RAM_BYTES   = 64'h0000_0000_0000_1000; // 1024 words
    localparam addr_t KEY_ADDR    = 64'h0000_0000_1000_0000;
    localparam addr_t SDRAM_BASE  = 64'h0000_0000_2000_0000;
    localparam addr_t SDRAM_BYTES = 64'h0000_0000_0080_0000; // 4M x 16 bit

endpackage

//--- src/target_if.sv
`timescale 1ns/1ps

interface target_if import mem_bus_pkg::*; ();

    addr_t    addr;   // byte offset inside the region
    ls_type_u ls;
    data_t    wdata;
    logic     start;  // one cycle
    logic     write;
    data_t    rdata;  // raw bytes in the low lanes
    logic     finish; // one cycle

    modport seq (
        output addr, ls, wdata, start, write,
        input  rdata, finish
    );

    modport tgt (
        input  addr, ls, wdata, start, write,
        output rdata, finish
    );

endinterface

//--- src/key_irq.sv
`timescale 1ns/1ps

module key_irq (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic [7:0] key_code,
    input  logic       key_press,
    input  logic       irq_ack,
    output logic [7:0] key_value,
    output logic       irq
);

    logic press_valid;

    assign press_valid = key_press && key_code != 8'd0;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_value <= 8'd0;
            irq       <= 1'b0;
        end else begin
            if (key_press) key_value <= key_code; // last code seen
            // press wins over a same-cycle ack
            if (press_valid)
                irq <= 1'b1;
            else if (irq_ack)
                irq <= 1'b0;
        end
    end

endmodule

//--- src/onchip_ram.sv
`timescale 1ns/1ps

module onchip_ram import mem_bus_pkg::*; #(
    parameter int RAM_WORDS = 1024
) (
    input  logic  CLOCK_50,
    input  logic  KEY0,
    target_if.tgt port
);

    localparam int IW = $clog2(RAM_WORDS);

    logic [31:0]   mem [RAM_WORDS];
    logic          second;    // high word beat of a double
    logic          is_double;
    logic          active;
    addr_t         word_full;
    logic [IW-1:0] word_idx;
    logic [3:0]    lane_we;
    logic [31:0]   lane_wdata;

    assign is_double = port.ls.fields.size == SIZE_DOUBLE;
    assign active    = port.start || second;
    assign word_full = (port.addr >> 2) + addr_t'(second);
    assign word_idx  = word_full[IW-1:0];

    // byte lanes for narrow stores
    always_comb begin
        lane_we    = 4'b1111;
        lane_wdata = port.wdata[31:0];
        case (port.ls.fields.size)
            SIZE_BYTE: begin
                lane_we    = 4'b0001 << port.addr[1:0];
                lane_wdata = {4{port.wdata[7:0]}};
            end
            SIZE_HALF: begin
                lane_we    = 4'b0011 << port.addr[1:0];
                lane_wdata = {2{port.wdata[15:0]}};
            end
            SIZE_DOUBLE: lane_wdata = second ? port.wdata[63:32] : port.wdata[31:0];
            default: lane_we = 4'b1111;
        endcase
    end

    always_ff @(posedge CLOCK_50) begin
        if (active && port.write) begin
            for (int b = 0; b < 4; b++) begin
                if (lane_we[b]) mem[word_idx][8*b +: 8] <= lane_wdata[8*b +: 8];
            end
        end
        if (active && !port.write) begin
            if (!is_double)
                port.rdata <= {32'd0, mem[word_idx] >> {port.addr[1:0], 3'b000}};
            else if (second)
                port.rdata[63:32] <= mem[word_idx];
            else
                port.rdata[31:0] <= mem[word_idx]; // low half first
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            second      <= 1'b0;
            port.finish <= 1'b0;
        end else begin
            second      <= port.start && is_double;
            port.finish <= (port.start && !is_double) || second;
        end
    end

    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        active |-> word_full < addr_t'(RAM_WORDS));

endmodule

//--- src/sdram_beats.sv
`timescale 1ns/1ps

module sdram_beats import mem_bus_pkg::*; #(
    parameter int SDRAM_AW = 22
) (
    input  logic                CLOCK_50,
    input  logic                KEY0,
    target_if.tgt               port,
    output logic [SDRAM_AW-1:0] sdram_addr,
    output logic [15:0]         sdram_wrdata,
    output logic [1:0]          sdram_byte_en,
    output logic                sdram_read_en,
    output logic                sdram_write_en,
    input  logic [15:0]         sdram_rddata,
    input  logic                sdram_wait
);

    logic        active;
    logic [1:0]  beat;
    logic [1:0]  last_beat;
    logic        is_byte;
    logic        beat_done;
    logic [15:0] beat_rdata;

    always_comb begin
        case (port.ls.fields.size)
            SIZE_BYTE, SIZE_HALF: last_beat = 2'd0;
            SIZE_WORD:            last_beat = 2'd1;
            default:              last_beat = 2'd3;
        endcase
    end

    assign is_byte   = port.ls.fields.size == SIZE_BYTE;
    assign beat_done = active && !sdram_wait; // wait low ends the beat

    assign sdram_read_en  = active && !port.write;
    assign sdram_write_en = active && port.write;
    assign sdram_addr     = port.addr[SDRAM_AW:1] + SDRAM_AW'(beat);
    assign sdram_byte_en  = is_byte ? (port.addr[0] ? 2'b10 : 2'b01) : 2'b11;
    assign sdram_wrdata   = is_byte ? {2{port.wdata[7:0]}} : port.wdata[16*beat +: 16];

    // odd byte comes in on the upper lane
    assign beat_rdata = (is_byte && port.addr[0]) ? {8'd0, sdram_rddata[15:8]} : sdram_rddata;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            active      <= 1'b0;
            beat        <= 2'd0;
            port.finish <= 1'b0;
        end else begin
            port.finish <= 1'b0;
            if (port.start) begin
                active <= 1'b1;
                beat   <= 2'd0;
            end else if (beat_done) begin
                if (beat == last_beat) begin
                    active      <= 1'b0;
                    port.finish <= 1'b1;
                end else begin
                    beat <= beat + 2'd1;
                end
            end
        end
    end

    // least significant beat lands lowest
    always_ff @(posedge CLOCK_50) begin
        if (beat_done && !port.write) port.rdata[16*beat +: 16] <= beat_rdata;
    end

    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !(sdram_read_en && sdram_write_en));

endmodule

//--- src/bus_sequencer.sv
`timescale 1ns/1ps

module bus_sequencer import mem_bus_pkg::*; (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  addr_t      bus_address,
    input  data_t      bus_write_data,
    input  ls_type_u   bus_ls_type,
    input  logic       bus_read_enable,
    input  logic       bus_write_enable,
    output logic       bus_read_done,
    output logic       bus_write_done,
    output data_t      bus_read_data,
    input  logic [7:0] key_value,
    target_if.seq      ram,
    target_if.seq      sdram
);

    localparam logic [1:0] S_IDLE   = 2'd0;
    localparam logic [1:0] S_DECODE = 2'd1;
    localparam logic [1:0] S_WAIT   = 2'd2;

    logic [1:0] state;
    logic       strobe;
    addr_t      req_addr;
    ls_type_u   req_ls;
    data_t      req_wdata;
    logic       req_write;
    region_e    region;
    logic       tgt_finish;
    data_t      load_value;

    function automatic data_t extend_load(data_t raw, ls_type_u ls);
        data_t v;
        case (ls.fields.size)
            SIZE_BYTE: v = ls.fields.zero_ext ? {56'd0, raw[7:0]} : {{56{raw[7]}}, raw[7:0]};
            SIZE_HALF: v = ls.fields.zero_ext ? {48'd0, raw[15:0]} : {{48{raw[15]}}, raw[15:0]};
            SIZE_WORD: v = ls.fields.zero_ext ? {32'd0, raw[31:0]} : {{32{raw[31]}}, raw[31:0]};
            default:   v = raw;
        endcase
        return v;
    endfunction

    assign strobe = bus_read_enable || bus_write_enable;

    // region of the held request
    always_comb begin
        if (req_addr >= RAM_BASE && req_addr < RAM_BASE + RAM_BYTES)
            region = REGION_RAM;
        else if (req_addr >= SDRAM_BASE && req_addr < SDRAM_BASE + SDRAM_BYTES)
            region = REGION_SDRAM;
        else if (req_addr == KEY_ADDR)
            region = REGION_KEY;
        else
            region = REGION_NONE;
    end

    // key and unmapped accesses answer themselves
    always_comb begin
        case (region)
            REGION_RAM: begin
                tgt_finish = ram.finish;
                load_value = extend_load(ram.rdata, req_ls);
            end
            REGION_SDRAM: begin
                tgt_finish = sdram.finish;
                load_value = extend_load(sdram.rdata, req_ls);
            end
            REGION_KEY: begin
                tgt_finish = 1'b1;
                load_value = {56'd0, key_value};
            end
            default: begin
                tgt_finish = 1'b1;
                load_value = '0;
            end
        endcase
    end

    assign ram.addr    = req_addr - RAM_BASE;
    assign ram.ls      = req_ls;
    assign ram.wdata   = req_wdata;
    assign ram.write   = req_write;
    assign sdram.addr  = req_addr - SDRAM_BASE;
    assign sdram.ls    = req_ls;
    assign sdram.wdata = req_wdata;
    assign sdram.write = req_write;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state          <= S_IDLE;
            bus_read_done  <= 1'b1;
            bus_write_done <= 1'b1;
            ram.start      <= 1'b0;
            sdram.start    <= 1'b0;
        end else begin
            ram.start   <= 1'b0;
            sdram.start <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (bus_read_enable) bus_read_done <= 1'b0;
                    if (bus_write_enable) bus_write_done <= 1'b0;
                    if (strobe) state <= S_DECODE;
                end
                S_DECODE: begin
                    ram.start   <= (region == REGION_RAM);
                    sdram.start <= (region == REGION_SDRAM);
                    state       <= S_WAIT;
                end
                default: begin
                    if (tgt_finish) begin
                        if (req_write) bus_write_done <= 1'b1;
                        else bus_read_done <= 1'b1;
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (state == S_IDLE && strobe) begin
            req_addr  <= bus_address;
            req_ls    <= bus_ls_type;
            req_wdata <= bus_write_data;
            req_write <= bus_write_enable;
        end
        if (state == S_WAIT && tgt_finish && !req_write)
            bus_read_data <= load_value;
    end

    // one access at a time, the core must wait for both dones
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        strobe |-> bus_read_done && bus_write_done && state == S_IDLE);

    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        bus_write_enable |-> bus_ls_type.raw inside {3'b000, 3'b001, 3'b010, 3'b011});

    // natural alignment only
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        strobe |-> (bus_address & ((addr_t'(1) << bus_ls_type.fields.size) - addr_t'(1))) == '0);

endmodule

//--- src/bus_bridge.sv
`timescale 1ns/1ps

module bus_bridge import mem_bus_pkg::*; #(
    parameter int RAM_WORDS = 1024,
    parameter int SDRAM_AW  = 22
) (
    input  logic                CLOCK_50,
    input  logic                KEY0,
    // cpu side
    input  addr_t               bus_address,
    input  data_t               bus_write_data,
    input  ls_type_u            bus_ls_type,
    input  logic                bus_read_enable,
    input  logic                bus_write_enable,
    output data_t               bus_read_data,
    output logic                bus_read_done,
    output logic                bus_write_done,
    // keyboard
    input  logic [7:0]          key_code,
    input  logic                key_press,
    input  logic                irq_ack,
    output logic                irq,
    // sdram side
    output logic [SDRAM_AW-1:0] sdram_addr,
    output logic [15:0]         sdram_wrdata,
    output logic [1:0]          sdram_byte_en,
    output logic                sdram_read_en,
    output logic                sdram_write_en,
    input  logic [15:0]         sdram_rddata,
    input  logic                sdram_wait
);

    logic [7:0] key_value;

    target_if ram_bus ();
    target_if sdram_bus ();

    bus_sequencer seq_i (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_ls_type      (bus_ls_type),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .bus_read_done    (bus_read_done),
        .bus_write_done   (bus_write_done),
        .bus_read_data    (bus_read_data),
        .key_value        (key_value),
        .ram              (ram_bus.seq),
        .sdram            (sdram_bus.seq)
    );

    onchip_ram #(.RAM_WORDS(RAM_WORDS)) ram_i (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .port     (ram_bus.tgt)
    );

    sdram_beats #(.SDRAM_AW(SDRAM_AW)) sdram_i (
        .CLOCK_50       (CLOCK_50),
        .KEY0           (KEY0),
        .port           (sdram_bus.tgt),
        .sdram_addr     (sdram_addr),
        .sdram_wrdata   (sdram_wrdata),
        .sdram_byte_en  (sdram_byte_en),
        .sdram_read_en  (sdram_read_en),
        .sdram_write_en (sdram_write_en),
        .sdram_rddata   (sdram_rddata),
        .sdram_wait     (sdram_wait)
    );

    key_irq key_i (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .key_code  (key_code),
        .key_press (key_press),
        .irq_ack   (irq_ack),
        .key_value (key_value),
        .irq       (irq)
    );

endmodule

//--- sim/sdram_model.sv
`timescale 1ns/1ps

module sdram_model #(
    parameter int AW = 22
) (
    input  logic          CLOCK_50,
    input  logic [AW-1:0] sdram_addr,
    input  logic [15:0]   sdram_wrdata,
    input  logic [1:0]    sdram_byte_en,
    input  logic          sdram_read_en,
    input  logic          sdram_write_en,
    output logic [15:0]   sdram_rddata,
    output logic          sdram_wait
);

    logic [15:0] mem [1<<AW];
    logic [31:0] lfsr      = 32'h0a6f8cf4;
    logic [1:0]  wait_left = 2'd0; // stall cycles left in this beat
    logic        busy;

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    assign busy         = sdram_read_en || sdram_write_en;
    assign sdram_wait   = busy && wait_left != 2'd0;
    assign sdram_rddata = mem[sdram_addr];

    always @(posedge CLOCK_50) begin : beat_blk
        logic [31:0] s;
        logic [1:0]  n;
        if (busy && wait_left != 2'd0) begin
            wait_left <= wait_left - 2'd1;
        end else if (busy) begin
            if (sdram_write_en) begin
                if (sdram_byte_en[0]) mem[sdram_addr][7:0] <= sdram_wrdata[7:0];
                if (sdram_byte_en[1]) mem[sdram_addr][15:8] <= sdram_wrdata[15:8];
            end
            // stall count for the next beat, one step per bit
            s    = lfsr_step(lfsr);
            n[0] = s[0];
            s    = lfsr_step(s);
            n[1] = s[0];
            lfsr      <= s;
            wait_left <= n;
        end
    end

endmodule

//--- sim/tb_bus_bridge.sv
`timescale 1ns/1ps

module tb_bus_bridge import mem_bus_pkg::*; ();

    localparam int RAM_WORDS = 1024;
    localparam int SDRAM_AW  = 22;

    // core ls codes
    localparam logic [2:0] LS_B  = 3'd0;
    localparam logic [2:0] LS_H  = 3'd1;
    localparam logic [2:0] LS_W  = 3'd2;
    localparam logic [2:0] LS_D  = 3'd3;
    localparam logic [2:0] LS_BU = 3'd4;
    localparam logic [2:0] LS_HU = 3'd5;
    localparam logic [2:0] LS_WU = 3'd6;

    typedef enum logic [2:0] {OP_WR, OP_RD, OP_KEY, OP_PRESS, OP_ACK, OP_IRQ} op_e;

    typedef struct packed {
        op_e        op;
        addr_t      addr;
        logic [2:0] ls;
        data_t      wdata;  // also the key code for a press
        data_t      exp;
    } row_t;

    logic                CLOCK_50 = 1'b0;
    logic                KEY0;
    addr_t               bus_address;
    data_t               bus_write_data;
    ls_type_u            bus_ls_type;
    logic                bus_read_enable;
    logic                bus_write_enable;
    data_t               bus_read_data;
    logic                bus_read_done;
    logic                bus_write_done;
    logic [7:0]          key_code;
    logic                key_press;
    logic                irq_ack;
    logic                irq;
    logic [SDRAM_AW-1:0] sdram_addr;
    logic [15:0]         sdram_wrdata;
    logic [1:0]          sdram_byte_en;
    logic                sdram_read_en;
    logic                sdram_write_en;
    logic [15:0]         sdram_rddata;
    logic                sdram_wait;

    row_t rows[$];
    int   cycles      = 0;
    int   cycle_limit = 0;

    bus_bridge #(.RAM_WORDS(RAM_WORDS), .SDRAM_AW(SDRAM_AW)) dut_i (.*);

    sdram_model #(.AW(SDRAM_AW)) sdram_i (.*);

    always #2 CLOCK_50 = ~CLOCK_50;

    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "run stopped at %0t ns", $time);
    endtask

    always @(posedge CLOCK_50) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: the run took more than %0d cycles", cycle_limit);
            abort_run();
        end
    end

    task automatic check_data(string what, data_t got, data_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s read data %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_irq(string what, logic got, logic exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s irq %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_key(string what, logic [7:0] got, logic [7:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s key %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_done(string what, logic got, logic exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s done %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    function automatic row_t make_row(op_e op, addr_t a, logic [2:0] ls, data_t wd, data_t exp);
        row_t r;
        r.op    = op;
        r.addr  = a;
        r.ls    = ls;
        r.wdata = wd;
        r.exp   = exp;
        return r;
    endfunction

    task automatic step_cycle();
        @(posedge CLOCK_50);
        #1;
    endtask

    // one strobe, then wait for the matching done to come back
    task automatic bus_access(input logic wr, input addr_t a, input logic [2:0] ls,
                              input data_t wd, output data_t rd);
        step_cycle();
        bus_address     = a;
        bus_ls_type.raw = ls;
        bus_write_data  = wd;
        if (wr) bus_write_enable = 1'b1;
        else bus_read_enable = 1'b1;
        step_cycle();
        bus_read_enable  = 1'b0;
        bus_write_enable = 1'b0;
        if ((wr ? bus_write_done : bus_read_done) !== 1'b0) begin
            $display("bus done did not fall after the strobe at %0t ns", $time);
            abort_run();
        end
        while ((wr ? bus_write_done : bus_read_done) !== 1'b1) step_cycle();
        rd = bus_read_data;
    endtask

    task automatic press_key(input logic [7:0] code);
        step_cycle();
        key_code  = code;
        key_press = 1'b1;
        step_cycle();
        key_press = 1'b0;
    endtask

    task automatic ack_irq();
        step_cycle();
        irq_ack = 1'b1;
        step_cycle();
        irq_ack = 1'b0;
    endtask

    task automatic build_table();
        // ram, little-endian bytes F1 F2 F3 F4 55 66 77 88
        rows.push_back(make_row(OP_WR, RAM_BASE, LS_D, 64'h8877_6655_F4F3_F2F1, '0));
        rows.push_back(make_row(OP_RD, RAM_BASE, LS_D, '0, 64'h8877_6655_F4F3_F2F1));
        rows.push_back(make_row(OP_RD, RAM_BASE, LS_B, '0, 64'hFFFF_FFFF_FFFF_FFF1));
        rows.push_back(make_row(OP_RD, RAM_BASE, LS_BU, '0, 64'h0000_0000_0000_00F1));
        rows.push_back(make_row(OP_RD, RAM_BASE + 3, LS_BU, '0, 64'h0000_0000_0000_00F4));
        rows.push_back(make_row(OP_RD, RAM_BASE + 2, LS_H, '0, 64'hFFFF_FFFF_FFFF_F4F3));
        rows.push_back(make_row(OP_RD, RAM_BASE + 2, LS_HU, '0, 64'h0000_0000_0000_F4F3));
        rows.push_back(make_row(OP_RD, RAM_BASE, LS_W, '0, 64'hFFFF_FFFF_F4F3_F2F1));
        rows.push_back(make_row(OP_RD, RAM_BASE + 4, LS_W, '0, 64'hFFFF_FFFF_8877_6655));
        rows.push_back(make_row(OP_RD, RAM_BASE + 4, LS_WU, '0, 64'h0000_0000_8877_6655));
        rows.push_back(make_row(OP_RD, RAM_BASE + 5, LS_B, '0, 64'h0000_0000_0000_0066));
        rows.push_back(make_row(OP_WR, RAM_BASE + 1, LS_B, 64'hFFFF_FFFF_FFFF_FFAB, '0));
        rows.push_back(make_row(OP_RD, RAM_BASE, LS_WU, '0, 64'h0000_0000_F4F3_ABF1));
        rows.push_back(make_row(OP_WR, RAM_BASE + 6, LS_H, 64'hFFFF_FFFF_FFFF_C0DE, '0));
        rows.push_back(make_row(OP_RD, RAM_BASE, LS_D, '0, 64'hC0DE_6655_F4F3_ABF1));
        rows.push_back(make_row(OP_WR, RAM_BASE + 8, LS_W, 64'hDEAD_BEEF_1234_5678, '0));
        rows.push_back(make_row(OP_RD, RAM_BASE + 8, LS_W, '0, 64'h0000_0000_1234_5678));
        rows.push_back(make_row(OP_WR, RAM_BASE + 12'hFF8, LS_D, 64'h0123_4567_89AB_CDEF, '0));
        rows.push_back(make_row(OP_RD, RAM_BASE + 12'hFF8, LS_D, '0, 64'h0123_4567_89AB_CDEF));
        // sdram, bytes 88 77 66 55 44 33 22 11
        rows.push_back(make_row(OP_WR, SDRAM_BASE, LS_D, 64'h1122_3344_5566_7788, '0));
        rows.push_back(make_row(OP_RD, SDRAM_BASE, LS_D, '0, 64'h1122_3344_5566_7788));
        rows.push_back(make_row(OP_RD, SDRAM_BASE + 2, LS_HU, '0, 64'h0000_0000_0000_5566));
        rows.push_back(make_row(OP_RD, SDRAM_BASE + 4, LS_W, '0, 64'h0000_0000_1122_3344));
        rows.push_back(make_row(OP_RD, SDRAM_BASE + 7, LS_B, '0, 64'h0000_0000_0000_0011));
        rows.push_back(make_row(OP_RD, SDRAM_BASE + 1, LS_B, '0, 64'h0000_0000_0000_0077));
        rows.push_back(make_row(OP_WR, SDRAM_BASE + 3, LS_B, 64'h0000_0000_0000_00C5, '0));
        rows.push_back(make_row(OP_RD, SDRAM_BASE + 2, LS_HU, '0, 64'h0000_0000_0000_C566));
        rows.push_back(make_row(OP_RD, SDRAM_BASE + 3, LS_B, '0, 64'hFFFF_FFFF_FFFF_FFC5));
        rows.push_back(make_row(OP_WR, SDRAM_BASE + 4, LS_B, 64'h0000_0000_0000_009A, '0));
        rows.push_back(make_row(OP_RD, SDRAM_BASE + 4, LS_H, '0, 64'h0000_0000_0000_339A));
        rows.push_back(make_row(OP_WR, SDRAM_BASE + 64'h100, LS_H, 64'h0000_0000_0000_BEEF, '0));
        rows.push_back(make_row(OP_RD, SDRAM_BASE + 64'h100, LS_H, '0, 64'hFFFF_FFFF_FFFF_BEEF));
        rows.push_back(make_row(OP_WR, SDRAM_BASE + 64'h200, LS_W, 64'h0000_0000_8765_4321, '0));
        rows.push_back(make_row(OP_RD, SDRAM_BASE + 64'h200, LS_WU, '0, 64'h0000_0000_8765_4321));
        rows.push_back(make_row(OP_RD, SDRAM_BASE + 64'h200, LS_W, '0, 64'hFFFF_FFFF_8765_4321));
        rows.push_back(make_row(OP_RD, SDRAM_BASE, LS_D, '0, 64'h1122_339A_C566_7788));
        // keyboard
        rows.push_back(make_row(OP_PRESS, '0, LS_B, 64'h41, '0));
        rows.push_back(make_row(OP_IRQ, '0, LS_B, '0, 64'd1));
        rows.push_back(make_row(OP_KEY, KEY_ADDR, LS_WU, '0, 64'h41));
        rows.push_back(make_row(OP_ACK, '0, LS_B, '0, '0));
        rows.push_back(make_row(OP_IRQ, '0, LS_B, '0, 64'd0));
        rows.push_back(make_row(OP_PRESS, '0, LS_B, 64'h00, '0));
        rows.push_back(make_row(OP_IRQ, '0, LS_B, '0, 64'd0));
        rows.push_back(make_row(OP_KEY, KEY_ADDR, LS_D, '0, 64'h00));
        // unmapped, just past each window
        rows.push_back(make_row(OP_WR, RAM_BASE + RAM_BYTES, LS_D, 64'hFFFF_FFFF_FFFF_FFFF, '0));
        rows.push_back(make_row(OP_WR, SDRAM_BASE + SDRAM_BYTES, LS_D, 64'hFFFF_FFFF_FFFF_FFFF, '0));
        rows.push_back(make_row(OP_RD, RAM_BASE, LS_D, '0, 64'hC0DE_6655_F4F3_ABF1));
        rows.push_back(make_row(OP_RD, 64'h0000_0000_0000_0800, LS_D, '0, '0));
        rows.push_back(make_row(OP_RD, SDRAM_BASE, LS_D, '0, 64'h1122_339A_C566_7788));
    endtask

    initial begin
        data_t rd;
        row_t  r;
        string what;
        KEY0             = 1'b0;
        bus_address      = '0;
        bus_write_data   = '0;
        bus_ls_type.raw  = 3'd0;
        bus_read_enable  = 1'b0;
        bus_write_enable = 1'b0;
        key_code         = 8'd0;
        key_press        = 1'b0;
        irq_ack          = 1'b0;
        build_table();
        cycle_limit = rows.size() * 40;
        repeat (3) @(posedge CLOCK_50);
        #1 KEY0 = 1'b1;
        check_done("read after reset", bus_read_done, 1'b1);
        check_done("write after reset", bus_write_done, 1'b1);
        check_irq("after reset", irq, 1'b0);
        foreach (rows[i]) begin
            r    = rows[i];
            what = $sformatf("row %0d", i);
            case (r.op)
                OP_WR: bus_access(1'b1, r.addr, r.ls, r.wdata, rd);
                OP_RD: begin
                    bus_access(1'b0, r.addr, r.ls, r.wdata, rd);
                    check_data(what, rd, r.exp);
                end
                OP_KEY: begin
                    bus_access(1'b0, r.addr, r.ls, r.wdata, rd);
                    check_key(what, rd[7:0], r.exp[7:0]);
                    check_data(what, rd, r.exp); // upper bytes zero
                end
                OP_PRESS: press_key(r.wdata[7:0]);
                OP_ACK:   ack_irq();
                OP_IRQ:   check_irq(what, irq, r.exp[0]);
                default: begin
                    $display("row %0d holds an unknown operation", i);
                    abort_run();
                end
            endcase
        end
        $display("Everything OK");
        $finish;
    end

endmodule

//--- filelist.f
src/mem_bus_pkg.sv
src/target_if.sv
src/key_irq.sv
src/onchip_ram.sv
src/sdram_beats.sv
src/bus_sequencer.sv
src/bus_bridge.sv
sim/sdram_model.sv
sim/tb_bus_bridge.sv

//--- Makefile
SIM      ?= verilator
TOP      ?= tb_bus_bridge
FILELIST ?= filelist.f
FLAGS    ?= --binary --timing --assert -j 0
BUILD    ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)
